// ==== rtl/count_pkg.sv ====
/*
 * Count definitions for the frame tagging path.
 * Sets the width of the per-word down-count and how it splits into bytes
 * for the pipelined counter. Also holds the counter phase type.
 */

package count_pkg;

    // Width of the count, cnt_limit and the count ports
    localparam int COUNT_WIDTH = 16;

    // Counter is built from two bytes of this width
    localparam int NIB_WIDTH = 8;

    // Startup forces a reload on the first accepted word
    typedef enum logic {
        PH_STARTUP,
        PH_RUN
    } count_phase_t;

endpackage

// ==== rtl/fifo_pkg.sv ====
/*
 * Default sizing of the tagged-word FIFO.
 * The top level uses these as its parameter defaults and passes them down.
 */

package fifo_pkg;

    // Eight entries
    localparam int FIFO_ADDR_WIDTH_DEF = 3;

    // Occupancy at or above this raises almost_full.
    // Keeps room for the two words in the tagger delay stages
    localparam int ALMOST_FULL_DEF = 5;

endpackage

// ==== rtl/tag_wr_if.sv ====
/*
 * Write side link from the count tagger into the tag FIFO.
 * A word is written on every cycle valid is high. There is no ready.
 * The tagger stops taking input on almost_full instead.
 */

`timescale 1ns/1ns

interface tag_wr_if import count_pkg::*; #(
    parameter int DATA_WIDTH = 32
);

    logic                   valid;
    logic [DATA_WIDTH-1:0]  data;
    logic [COUNT_WIDTH-1:0] count;
    logic                   final_cnt;      // Count of this word is zero
    logic                   almost_full;    // Back from the FIFO

    modport tagger (
        output valid, data, count, final_cnt,
        input  almost_full
    );

    modport fifo (
        input  valid, data, count, final_cnt,
        output almost_full
    );

endinterface

// ==== rtl/count_tagger.sv ====
/*
 * Tags each accepted word with a repeating down-count from cnt_limit to 0.
 * The counter is split into a low and a high byte. The high byte takes the
 * low byte's borrow one cycle later and the data is delayed two stages to
 * meet its count. A word accepted at edge N is written out at edge N+2.
 */

`timescale 1ns/1ns

module count_tagger import count_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   sync_reset,

    input  logic                   s_tvalid,
    input  logic [DATA_WIDTH-1:0]  s_tdata,
    output logic                   s_tready,

    input  logic [COUNT_WIDTH-1:0] cnt_limit,

    tag_wr_if.tagger               wr
);

    logic                   take;
    count_phase_t           phase;

    // Low byte plus its borrow in the top bit
    logic [NIB_WIDTH:0]     cnt_lo;
    logic [NIB_WIDTH-1:0]   cnt_hi;
    logic [NIB_WIDTH-1:0]   borrow;

    logic [NIB_WIDTH-1:0]   lim_lo;
    logic [NIB_WIDTH-1:0]   lim_hi;

    logic                   hi_zero;
    logic                   frame_end;
    logic                   reload;
    logic                   reload_d0;      // Last accepted word reloaded

    logic                   take_d0;
    logic                   take_d1;
    logic [NIB_WIDTH-1:0]   lo_d0;
    logic [DATA_WIDTH-1:0]  data_d0;
    logic [DATA_WIDTH-1:0]  data_d1;
    logic [COUNT_WIDTH-1:0] count_s;

    assign s_tready = ~wr.almost_full;
    assign take     = s_tvalid & s_tready & ~sync_reset;

    assign lim_lo = cnt_limit[NIB_WIDTH-1:0];
    assign lim_hi = cnt_limit[COUNT_WIDTH-1 -: NIB_WIDTH];

    assign borrow = {{(NIB_WIDTH-1){1'b0}}, cnt_lo[NIB_WIDTH]};

    // High byte of the last accepted word.
    // A reload still pending in the high byte shows up as lim_hi.
    // A pending borrow can be ignored here since it leaves the low byte at all ones
    assign hi_zero = reload_d0 ? (lim_hi == '0) : (cnt_hi == '0);

    assign frame_end = (cnt_lo[NIB_WIDTH-1:0] == '0) & hi_zero;
    assign reload    = (phase == PH_STARTUP) | frame_end;

    // Control state and the split counter
    always_ff @(posedge clk) begin
        if (sync_reset) begin
            phase     <= PH_STARTUP;
            cnt_lo    <= {1'b0, lim_lo};
            cnt_hi    <= lim_hi;
            reload_d0 <= 1'b0;
            take_d0   <= 1'b0;
            take_d1   <= 1'b0;
        end else begin
            take_d0   <= take;
            take_d1   <= take_d0;
            reload_d0 <= take & reload;

            if (take) begin
                phase <= PH_RUN;
                if (reload) begin
                    cnt_lo <= {1'b0, lim_lo};
                end else begin
                    cnt_lo <= {1'b0, cnt_lo[NIB_WIDTH-1:0]} - 1'b1;    // Top bit catches the borrow
                end
            end

            // High byte follows one cycle behind the low byte
            if (reload_d0) begin
                cnt_hi <= lim_hi;
            end else if (take_d0) begin
                cnt_hi <= cnt_hi - borrow;
            end
        end
    end

    // Payload delay, free running
    always_ff @(posedge clk) begin
        data_d0 <= s_tdata;
        data_d1 <= data_d0;
        lo_d0   <= cnt_lo[NIB_WIDTH-1:0];   // Low byte of the word in stage one
    end

    // Delayed low byte meets the freshly updated high byte
    assign count_s = {cnt_hi, lo_d0};

    assign wr.valid     = take_d1;
    assign wr.data      = data_d1;
    assign wr.count     = count_s;
    assign wr.final_cnt = (count_s == '0);

endmodule

// ==== rtl/tag_fifo.sv ====
/*
 * Synchronous FIFO for tagged words with first-word fall-through output.
 * Each entry holds the data, its count and the final flag.
 * almost_full is raised from the occupancy and throttles the tagger input.
 */

`timescale 1ns/1ns

module tag_fifo import count_pkg::*, fifo_pkg::*; #(
    parameter int DATA_WIDTH         = 32,
    parameter int FIFO_ADDR_WIDTH    = FIFO_ADDR_WIDTH_DEF,
    parameter int ALMOST_FULL_THRESH = ALMOST_FULL_DEF
) (
    input  logic                   clk,
    input  logic                   sync_reset,

    tag_wr_if.fifo                 wr,

    output logic                   m_tvalid,
    output logic [DATA_WIDTH-1:0]  m_tdata,
    output logic [COUNT_WIDTH-1:0] m_count,
    output logic                   m_final_cnt,
    input  logic                   m_tready
);

    localparam int DEPTH       = 1 << FIFO_ADDR_WIDTH;
    localparam int ENTRY_WIDTH = DATA_WIDTH + COUNT_WIDTH + 1;

    localparam logic [FIFO_ADDR_WIDTH:0] AF_LEVEL =
        (FIFO_ADDR_WIDTH+1)'(ALMOST_FULL_THRESH);

    logic [ENTRY_WIDTH-1:0]     mem [DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0]   occupancy;     // One bit wider to hold a full count

    logic                       wr_en;
    logic                       rd_en;
    logic [ENTRY_WIDTH-1:0]     rd_entry;

    assign wr_en = wr.valid;                // Room is guaranteed by the threshold
    assign rd_en = m_tvalid & m_tready;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {wr.final_cnt, wr.count, wr.data};
        end
    end

    // Pointers wrap on their own at the power of two depth
    always_ff @(posedge clk) begin
        if (sync_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;    // Idle or write with read
            endcase
        end
    end

    assign wr.almost_full = (occupancy >= AF_LEVEL);

    // Head entry is shown as soon as it lands
    assign rd_entry = mem[rd_ptr];
    assign m_tvalid = (occupancy != '0);

    assign m_tdata     = rd_entry[DATA_WIDTH-1:0];
    assign m_count     = rd_entry[DATA_WIDTH +: COUNT_WIDTH];
    assign m_final_cnt = rd_entry[ENTRY_WIDTH-1];

endmodule

// ==== rtl/cycle_count_align.sv ====
/*
 * Top level of the count alignment block.
 * Input words are tagged with a repeating down-count from cnt_limit and
 * the word with count 0 is flagged final. cnt_limit may only change while
 * sync_reset is high. Both streams use a plain valid/ready handshake.
 */

`timescale 1ns/1ns

module cycle_count_align import count_pkg::*, fifo_pkg::*; #(
    parameter int DATA_WIDTH         = 32,
    parameter int FIFO_ADDR_WIDTH    = FIFO_ADDR_WIDTH_DEF,
    parameter int ALMOST_FULL_THRESH = ALMOST_FULL_DEF
) (
    input  logic                   clk,
    input  logic                   sync_reset,

    input  logic                   s_tvalid,
    input  logic [DATA_WIDTH-1:0]  s_tdata,
    output logic                   s_tready,

    input  logic [COUNT_WIDTH-1:0] cnt_limit,

    output logic                   m_tvalid,
    output logic [DATA_WIDTH-1:0]  m_tdata,
    output logic [COUNT_WIDTH-1:0] m_count,
    output logic                   m_final_cnt,
    input  logic                   m_tready
);

    // Tagged words from the tagger into the FIFO
    tag_wr_if #(
        .DATA_WIDTH (DATA_WIDTH)
    ) tag_wr ();

    count_tagger #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_tagger (
        .clk        (clk),
        .sync_reset (sync_reset),
        .s_tvalid   (s_tvalid),
        .s_tdata    (s_tdata),
        .s_tready   (s_tready),
        .cnt_limit  (cnt_limit),
        .wr         (tag_wr.tagger)
    );

    tag_fifo #(
        .DATA_WIDTH         (DATA_WIDTH),
        .FIFO_ADDR_WIDTH    (FIFO_ADDR_WIDTH),
        .ALMOST_FULL_THRESH (ALMOST_FULL_THRESH)
    ) u_fifo (
        .clk         (clk),
        .sync_reset  (sync_reset),
        .wr          (tag_wr.fifo),
        .m_tvalid    (m_tvalid),
        .m_tdata     (m_tdata),
        .m_count     (m_count),
        .m_final_cnt (m_final_cnt),
        .m_tready    (m_tready)
    );

endmodule

// ==== verif/tb_cycle_count_align.sv ====
/*
 * Testbench for the count alignment block.
 * Drives LFSR-chosen words and ready stalls, keeps a reference count model
 * in a queue and compares every output word against it. Runs four phases,
 * each starting with a reset and a new cnt_limit. The later resets land
 * on a FIFO that was filled with the output held off.
 */

`timescale 1ns/1ns

module tb_cycle_count_align import count_pkg::*; ();

    localparam int          DATA_WIDTH   = 32;
    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'h2beca4c6;

    // Words per phase
    localparam int N_CONT    = 240;
    localparam int N_RANDOM  = 300;
    localparam int N_BORROW  = 300;
    localparam int N_ZERO    = 40;
    localparam int NUM_PHASE = 4;

    localparam int TOTAL_WORDS = N_CONT + N_RANDOM + N_BORROW + N_ZERO;
    localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + NUM_PHASE * RESET_CYCLES;

    logic                   clk;
    logic                   sync_reset;
    logic                   s_tvalid;
    logic [DATA_WIDTH-1:0]  s_tdata;
    logic                   s_tready;
    logic [COUNT_WIDTH-1:0] cnt_limit;
    logic                   m_tvalid;
    logic [DATA_WIDTH-1:0]  m_tdata;
    logic [COUNT_WIDTH-1:0] m_count;
    logic                   m_final_cnt;
    logic                   m_tready;

    logic [31:0]            src_state;      // LFSR for valid gaps and data
    logic [31:0]            sink_state;     // LFSR for ready stalls
    logic                   stall_mode;
    logic                   hold_off;       // Output ready held low
    int                     stall_cyc;

    // Reference model state
    logic [DATA_WIDTH-1:0]  exp_data_q [$];
    logic [COUNT_WIDTH-1:0] exp_count_q [$];
    logic [COUNT_WIDTH-1:0] prev_count;
    logic [COUNT_WIDTH-1:0] exp_c;
    logic [DATA_WIDTH-1:0]  exp_d;
    logic                   startup;
    logic                   rst_seen;
    logic                   saw_tready_low;

    int                     in_count;
    int                     out_count;
    int                     dropped;        // Words cleared by a reset
    int                     cycles;
    int                     value_errors;
    int                     other_errors;

    cycle_count_align #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_dut (
        .clk         (clk),
        .sync_reset  (sync_reset),
        .s_tvalid    (s_tvalid),
        .s_tdata     (s_tdata),
        .s_tready    (s_tready),
        .cnt_limit   (cnt_limit),
        .m_tvalid    (m_tvalid),
        .m_tdata     (m_tdata),
        .m_count     (m_count),
        .m_final_cnt (m_final_cnt),
        .m_tready    (m_tready)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            val   = {val[30:0], state[0]};
        end
    endtask

    // Down-count with reload after 0 and on the first word after reset
    function automatic logic [COUNT_WIDTH-1:0] next_count(
        input logic [COUNT_WIDTH-1:0] prev,
        input logic                   first,
        input logic [COUNT_WIDTH-1:0] limit
    );
        if (first || prev == '0) begin
            return limit;
        end
        return prev - 16'd1;
    endfunction

    task automatic apply_reset(input logic [COUNT_WIDTH-1:0] lim);
        @(negedge clk);
        sync_reset = 1'b1;
        cnt_limit  = lim;       // Only changes while in reset
        repeat (RESET_CYCLES) @(negedge clk);
        sync_reset = 1'b0;
    endtask

    // Each word is held until the monitor has seen it accepted
    task automatic send_words(input int n, input logic gaps);
        logic [31:0] r;
        int          start;
        start = in_count;
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                draw_bits(src_state, 2, r);
                while (r == 32'd0) begin
                    s_tvalid = 1'b0;
                    @(negedge clk);
                    draw_bits(src_state, 2, r);
                end
            end
            draw_bits(src_state, 32, r);
            s_tvalid = 1'b1;
            s_tdata  = r;
            do @(negedge clk); while (in_count == start + i);
        end
        s_tvalid = 1'b0;
    endtask

    // Output held off until input ready drops, so the next reset meets a full FIFO
    task automatic fill_fifo();
        logic [31:0] r;
        hold_off = 1'b1;
        @(negedge clk);
        while (s_tready) begin
            draw_bits(src_state, 32, r);
            s_tvalid = 1'b1;
            s_tdata  = r;
            @(negedge clk);
        end
        s_tvalid = 1'b0;
    endtask

    task automatic drain_fifo();
        while (exp_data_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (out_count + dropped == in_count) else begin
            other_errors++;
            $display("Word count mismatch after drain: %0d in, %0d out, %0d dropped",
                     in_count, out_count, dropped);
        end
        assert (!m_tvalid) else begin
            other_errors++;
            $display("Output still valid after all expected words left");
        end
    endtask

    task automatic run_phase(input logic [COUNT_WIDTH-1:0] lim, input int n, input logic rnd);
        apply_reset(lim);
        hold_off       = 1'b0;
        saw_tready_low = 1'b0;
        stall_mode     = rnd;
        send_words(n, rnd);
        drain_fifo();
        stall_mode = 1'b0;
        if (rnd) begin
            assert (saw_tready_low) else begin
                other_errors++;
                $display("Input ready never dropped during the long output stalls");
            end
        end
    endtask

    task automatic report_counts();
        $display("Words in %0d, out %0d, dropped %0d, value errors %0d, other errors %0d",
                 in_count, out_count, dropped, value_errors, other_errors);
    endtask

    // Output ready with a long stall every 64 cycles plus short random ones
    always @(negedge clk) begin
        logic [31:0] r;
        if (hold_off) begin
            m_tready = 1'b0;
        end else if (stall_mode) begin
            if ((stall_cyc % 64) < 16) begin
                m_tready = 1'b0;
            end else begin
                draw_bits(sink_state, 2, r);
                m_tready = (r != 32'd0);
            end
            stall_cyc++;
        end else begin
            m_tready  = 1'b1;
            stall_cyc = 0;
        end
    end

    // Reference model and checker
    always @(posedge clk) begin
        if (rst_seen) begin
            assert (!m_tvalid) else begin
                other_errors++;
                $display("Output valid high during or right after reset");
            end
            assert (s_tready) else begin
                other_errors++;
                $display("Input ready low during or right after reset");
            end
        end
        if (sync_reset) begin
            startup = 1'b1;
            dropped += exp_data_q.size();
            exp_data_q.delete();
            exp_count_q.delete();
        end else begin
            if (s_tvalid && s_tready) begin
                exp_c      = next_count(prev_count, startup, cnt_limit);
                startup    = 1'b0;
                prev_count = exp_c;
                exp_data_q.push_back(s_tdata);
                exp_count_q.push_back(exp_c);
                in_count++;
            end
            if (stall_mode && !s_tready) begin
                saw_tready_low = 1'b1;
            end
            if (m_tvalid && m_tready) begin
                out_count++;
                if (exp_data_q.size() == 0) begin
                    other_errors++;
                    $display("Output word arrived while no word was expected");
                end else begin
                    exp_d = exp_data_q.pop_front();
                    exp_c = exp_count_q.pop_front();
                    assert (m_tdata == exp_d) else begin
                        value_errors++;
                        $display("[FAIL] m_tdata got %h expected %h", m_tdata, exp_d);
                    end
                    assert (m_count == exp_c) else begin
                        value_errors++;
                        $display("[FAIL] m_count got %h expected %h", m_count, exp_c);
                    end
                    assert (m_final_cnt == (exp_c == '0)) else begin
                        value_errors++;
                        $display("[FAIL] m_final_cnt got %h expected %h",
                                 m_final_cnt, (exp_c == '0));
                    end
                end
            end
        end
        rst_seen = sync_reset;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            other_errors++;
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            report_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        sync_reset   = 1'b1;
        s_tvalid     = 1'b0;
        s_tdata      = '0;
        cnt_limit    = 16'd5;
        m_tready     = 1'b1;
        stall_mode   = 1'b0;
        hold_off     = 1'b0;
        stall_cyc    = 0;
        prev_count   = '0;
        startup      = 1'b1;
        rst_seen     = 1'b0;
        in_count     = 0;
        out_count    = 0;
        dropped      = 0;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        src_state    = SEED;
        sink_state   = SEED;
        draw_bits(sink_state, 17, r);   // Offset the ready stream from the data stream

        run_phase(16'd5, N_CONT, 1'b0);        // Plain 5..0 frames at full rate
        fill_fifo();
        run_phase(16'd9, N_RANDOM, 1'b1);      // Gaps and stalls
        fill_fifo();
        run_phase(16'h0102, N_BORROW, 1'b1);   // High byte borrow and reload
        fill_fifo();
        run_phase(16'd0, N_ZERO, 1'b0);        // Every word final

        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/count_pkg.sv
rtl/fifo_pkg.sv
rtl/tag_wr_if.sv
rtl/count_tagger.sv
rtl/tag_fifo.sv
rtl/cycle_count_align.sv
verif/tb_cycle_count_align.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the count alignment testbench with Verilator.
# Exits nonzero unless the simulation prints the pass message.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -Wno-fatal \
    --top-module tb_cycle_count_align \
    --Mdir obj_dir \
    -o sim_tb \
    -f tb.f

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q -F '*** PASSED ***'; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
